// ==== tb.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/bus_if.sv
rtl/bus_arbiter.sv
rtl/icache.sv
rtl/dcache.sv
rtl/block_ram.sv
rtl/mem_system.sv
verification/mem_checker.sv
verification/tb_mem_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mem_system -f tb.f -o sim_mem_system
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_mem_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "** FAIL **" sim.log; then
	exit 1
fi
exit 0

// ==== verification/tb_mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_mem_system;

	localparam int MAX_WAIT = 200;

	logic clk;
	logic reset;
	mem_pkg::addr_t icache_rd_addr;
	logic icache_rd_req;
	logic icache_rd_wait;
	mem_pkg::word_t icache_rd_data;
	mem_pkg::addr_t dcache_addr;
	logic dcache_rd_req;
	logic dcache_wr_req;
	logic dcache_rw_wait;
	mem_pkg::word_t dcache_wr_data;
	mem_pkg::word_t dcache_rd_data;

	mem_pkg::word_t wr_words [`MEM_RAM_WORDS];
	int tb_checks = 0;
	int tb_errors = 0;
	int errors_before = 0;

	mem_system u_mem_system (
		.clk(clk),
		.reset(reset),
		.icache_rd_addr(icache_rd_addr),
		.icache_rd_req(icache_rd_req),
		.icache_rd_wait(icache_rd_wait),
		.icache_rd_data(icache_rd_data),
		.dcache_addr(dcache_addr),
		.dcache_rd_req(dcache_rd_req),
		.dcache_wr_req(dcache_wr_req),
		.dcache_rw_wait(dcache_rw_wait),
		.dcache_wr_data(dcache_wr_data),
		.dcache_rd_data(dcache_rd_data)
	);

	mem_checker u_mem_checker (
		.clk(clk),
		.reset(reset),
		.icache_rd_addr(icache_rd_addr),
		.icache_rd_req(icache_rd_req),
		.icache_rd_wait(icache_rd_wait),
		.icache_rd_data(icache_rd_data),
		.dcache_addr(dcache_addr),
		.dcache_rd_req(dcache_rd_req),
		.dcache_wr_req(dcache_wr_req),
		.dcache_rw_wait(dcache_rw_wait),
		.dcache_wr_data(dcache_wr_data),
		.dcache_rd_data(dcache_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ************************************************************
	// access tasks
	// ************************************************************

	function automatic mem_pkg::addr_t random_addr();
		logic [31:0] rnd;
		rnd = $urandom();
		return {24'h000000, rnd[7:2], 2'b00}; // stays inside the ram.
	endfunction

	task automatic wait_for_completion(input bit on_icache, output int cycles);
		cycles = 0;
		@(negedge clk);
		while ((on_icache ? icache_rd_wait : dcache_rw_wait) && cycles < MAX_WAIT)
		begin
			cycles++;
			@(negedge clk);
		end
		if (on_icache ? icache_rd_wait : dcache_rw_wait)
		begin
			tb_errors++;
			$display("%s access never completed within %0d cycles",
				on_icache ? "icache" : "dcache", MAX_WAIT);
		end
	endtask

	task automatic icache_read(input mem_pkg::addr_t addr, output mem_pkg::word_t data,
		output int latency);
		@(posedge clk);
		#2;
		icache_rd_addr = addr;
		icache_rd_req = 1'b1;
		wait_for_completion(1'b1, latency);
		data = icache_rd_data;
		@(posedge clk);
		#2;
		icache_rd_req = 1'b0;
	endtask

	task automatic dcache_access(input bit write, input mem_pkg::addr_t addr,
		input mem_pkg::word_t wdata, output mem_pkg::word_t data, output int latency);
		@(posedge clk);
		#2;
		dcache_addr = addr;
		dcache_wr_data = wdata;
		dcache_rd_req = !write;
		dcache_wr_req = write;
		wait_for_completion(1'b0, latency);
		data = dcache_rd_data;
		@(posedge clk);
		#2;
		dcache_rd_req = 1'b0;
		dcache_wr_req = 1'b0;
	endtask

	task automatic check_latency(input string what, input int latency, input bit want_hit);
		tb_checks++;
		if (want_hit && latency != 0)
		begin
			tb_errors++;
			$display("%s should hit with no wait but waited %0d cycles", what, latency);
		end
		else if (!want_hit && latency == 0)
		begin
			tb_errors++;
			$display("%s should miss and stall but completed at once", what);
		end
	endtask

	task automatic check_word(input string name, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		tb_checks++;
		if (actual !== expected)
		begin
			tb_errors++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic int error_total();
		return tb_errors + u_mem_checker.fail_count;
	endfunction

	task automatic end_test(input string name);
		if (error_total() == errors_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, error_total() - errors_before);
		errors_before = error_total();
	endtask

	// ************************************************************
	// stimulus
	// ************************************************************

	initial
	begin
		mem_pkg::addr_t a;
		mem_pkg::addr_t x;
		mem_pkg::addr_t ia;
		mem_pkg::addr_t da;
		mem_pkg::word_t dw;
		mem_pkg::word_t data;
		mem_pkg::word_t data2;
		mem_pkg::word_t old_word;
		logic [31:0] rnd;
		int latency;
		int latency2;
		int total;

		void'($urandom(32'h3387));
		reset = 1'b1;
		icache_rd_addr = '0;
		icache_rd_req = 1'b0;
		dcache_addr = '0;
		dcache_rd_req = 1'b0;
		dcache_wr_req = 1'b0;
		dcache_wr_data = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		for (int i = 0; i < `MEM_RAM_WORDS; i++)
		begin
			wr_words[i] = $urandom();
			dcache_access(1'b1, i * 4, wr_words[i], data, latency);
		end
		for (int i = 0; i < `MEM_RAM_WORDS; i++)
		begin
			dcache_access(1'b0, i * 4, '0, data, latency);
			check_word("dcache_rd_data", wr_words[i], data);
		end
		end_test("1 initialisation");

		for (int k = 0; k < 4; k++)
		begin
			a = random_addr();
			dcache_access(1'b0, a, '0, data, latency);
			dcache_access(1'b0, a, '0, data, latency);
			check_latency("dcache repeat read", latency, 1'b1);
			a = random_addr();
			icache_read(a, data, latency);
			icache_read(a, data, latency);
			check_latency("icache repeat read", latency, 1'b1);
		end
		end_test("2 hit timing");

		a = random_addr() & 32'h0000003c;
		dcache_access(1'b0, a, '0, data, latency);
		icache_read(a + 128, data, latency);
		for (int k = 0; k < 3; k++)
		begin
			dcache_access(1'b0, a + 64, '0, data, latency);
			check_latency("dcache conflict read", latency, 1'b0);
			dcache_access(1'b0, a, '0, data, latency);
			check_latency("dcache conflict read", latency, 1'b0);
			icache_read(a + 192, data, latency);
			check_latency("icache conflict read", latency, 1'b0);
			icache_read(a + 128, data, latency);
			check_latency("icache conflict read", latency, 1'b0);
		end
		end_test("3 conflict misses");

		x = random_addr();
		old_word = wr_words[x[7:2]]; // ram still holds the words written in test 1.
		icache_read(x, data, latency);
		check_word("icache_rd_data", old_word, data);
		dcache_access(1'b1, x, ~old_word, data, latency);
		icache_read(x, data, latency);
		check_word("icache_rd_data", old_word, data); // icache is not coherent.
		icache_read(x ^ 32'h00000040, data, latency);
		icache_read(x, data, latency);
		check_word("icache_rd_data", ~old_word, data);
		end_test("4 stale icache");

		for (int n = 0; n < 100; n++)
		begin
			ia = random_addr();
			da = random_addr();
			dw = $urandom();
			rnd = $urandom();
			fork
				icache_read(ia, data, latency);
				dcache_access(rnd[0], da, dw, data2, latency2);
			join
		end
		end_test("5 concurrent access");

		total = error_total();
		$display("checks %0d, errors %0d", tb_checks + u_mem_checker.check_count, total);
		if (total == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/mem_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_checker (
	input wire clk,
	input wire reset,
	input wire mem_pkg::addr_t icache_rd_addr,
	input wire icache_rd_req,
	input wire icache_rd_wait,
	input wire mem_pkg::word_t icache_rd_data,
	input wire mem_pkg::addr_t dcache_addr,
	input wire dcache_rd_req,
	input wire dcache_wr_req,
	input wire dcache_rw_wait,
	input wire mem_pkg::word_t dcache_wr_data,
	input wire mem_pkg::word_t dcache_rd_data
);

	localparam int ICACHE = 0;
	localparam int DCACHE = 1;
	localparam int RAM_ADDR_BITS = $clog2(`MEM_RAM_WORDS);

	mem_pkg::word_t ram_model [`MEM_RAM_WORDS];
	logic line_valid [2][`MEM_LINES];
	mem_pkg::tag_t line_tag [2][`MEM_LINES];
	mem_pkg::word_t line_word [2][`MEM_LINES];

	int check_count = 0;
	int fail_count = 0;

	// ************************************************************
	// reference models
	// ************************************************************

	// a tag miss installs the ram word, as both caches fill on a read miss.
	function automatic mem_pkg::word_t expected_read(input int cache, input mem_pkg::addr_t addr);
		logic [`MEM_INDEX_BITS-1:0] index;
		mem_pkg::tag_t tag;
		index = addr[`MEM_INDEX_BITS+1:2];
		tag = addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
		if (!(line_valid[cache][index] && line_tag[cache][index] == tag))
		begin
			line_valid[cache][index] = 1'b1;
			line_tag[cache][index] = tag;
			line_word[cache][index] = ram_model[addr[RAM_ADDR_BITS+1:2]];
		end
		return line_word[cache][index];
	endfunction

	task automatic record_write(input mem_pkg::addr_t addr, input mem_pkg::word_t word);
		logic [`MEM_INDEX_BITS-1:0] index;
		index = addr[`MEM_INDEX_BITS+1:2];
		ram_model[addr[RAM_ADDR_BITS+1:2]] = word;
		line_valid[DCACHE][index] = 1'b1; // write allocates, hit or miss.
		line_tag[DCACHE][index] = addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
		line_word[DCACHE][index] = word;
	endtask

	task automatic compare_word(input string name, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			fail_count++;
			$display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	// ************************************************************
	// completion detection, mid cycle
	// ************************************************************

	always @(negedge clk)
	begin
		if (reset)
		begin
			for (int c = 0; c < 2; c++)
				for (int i = 0; i < `MEM_LINES; i++)
					line_valid[c][i] = 1'b0;
		end
		else
		begin
			if (icache_rd_req && !icache_rd_wait)
				compare_word("icache_rd_data", expected_read(ICACHE, icache_rd_addr),
					icache_rd_data);
			if (dcache_wr_req && !dcache_rw_wait)
				record_write(dcache_addr, dcache_wr_data);
			else if (dcache_rd_req && !dcache_rw_wait)
				compare_word("dcache_rd_data", expected_read(DCACHE, dcache_addr),
					dcache_rd_data);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input wire clk,
	input wire reset,
	input wire mem_pkg::addr_t icache_rd_addr,
	input wire icache_rd_req,
	output wire icache_rd_wait,
	output wire mem_pkg::word_t icache_rd_data,
	input wire mem_pkg::addr_t dcache_addr,
	input wire dcache_rd_req,
	input wire dcache_wr_req,
	output wire dcache_rw_wait,
	input wire mem_pkg::word_t dcache_wr_data,
	output wire mem_pkg::word_t dcache_rd_data
);

	bus_if icache_bus ();
	bus_if dcache_bus ();
	bus_if ram_bus ();

	// ************************************************************
	// caches
	// ************************************************************

	icache u_icache (
		.clk(clk),
		.reset(reset),
		.rd_addr(icache_rd_addr),
		.rd_req(icache_rd_req),
		.rd_wait(icache_rd_wait),
		.rd_data(icache_rd_data),
		.bus(icache_bus.master)
	);

	dcache u_dcache (
		.clk(clk),
		.reset(reset),
		.addr(dcache_addr),
		.rd_req(dcache_rd_req),
		.wr_req(dcache_wr_req),
		.rw_wait(dcache_rw_wait),
		.wr_data(dcache_wr_data),
		.rd_data(dcache_rd_data),
		.bus(dcache_bus.master)
	);

	// ************************************************************
	// shared bus and backing store
	// ************************************************************

	bus_arbiter u_bus_arbiter (
		.clk(clk),
		.reset(reset),
		.icache_bus(icache_bus.arbiter),
		.dcache_bus(dcache_bus.arbiter),
		.ram_bus(ram_bus.master)
	);

	block_ram u_block_ram (
		.clk(clk),
		.bus(ram_bus.slave)
	);

endmodule

`default_nettype wire

// ==== rtl/block_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module block_ram (
	input wire clk,
	bus_if.slave bus
);

	localparam int RAM_ADDR_BITS = $clog2(`MEM_RAM_WORDS);

	mem_pkg::word_t mem [`MEM_RAM_WORDS];
	logic [RAM_ADDR_BITS-1:0] word_addr;

	// high addresses alias onto the low 256 bytes.
	assign word_addr = bus.addr[RAM_ADDR_BITS+1:2];

	// ************************************************************
	// one access per strobe, ready in the following cycle
	// ************************************************************

	always_ff @(posedge clk)
	begin
		bus.ready <= bus.rd || bus.wr;
		if (bus.wr)
			mem[word_addr] <= bus.wdata;
		if (bus.rd)
			bus.rdata <= mem[word_addr];
	end

endmodule

`default_nettype wire

// ==== rtl/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module dcache (
	input wire clk,
	input wire reset,
	input wire mem_pkg::addr_t addr,
	input wire rd_req,
	input wire wr_req,
	output logic rw_wait,
	input wire mem_pkg::word_t wr_data,
	output mem_pkg::word_t rd_data,
	bus_if.master bus
);

	logic [`MEM_LINES-1:0] valid;
	mem_pkg::tag_t tags [`MEM_LINES];
	mem_pkg::word_t data [`MEM_LINES];

	mem_pkg::fill_state_e state;
	mem_pkg::addr_t fill_addr;
	mem_pkg::word_t fill_wdata;
	logic is_write;
	logic write_done;

	logic [`MEM_INDEX_BITS-1:0] index;
	logic [`MEM_INDEX_BITS-1:0] fill_index;
	mem_pkg::tag_t tag;
	logic hit;
	logic start;
	logic finish;

	assign index = addr[`MEM_INDEX_BITS+1:2];
	assign tag = addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
	assign fill_index = fill_addr[`MEM_INDEX_BITS+1:2];
	assign hit = valid[index] && (tags[index] == tag);

	// write_done marks the one cycle in which a finished write completes.
	assign start = (rd_req && !hit) || (wr_req && !write_done);
	assign finish = (state == mem_pkg::FILL_WAIT_READY) && bus.ready;

	assign rd_data = data[index];
	assign rw_wait = (rd_req && (!hit || state != mem_pkg::FILL_IDLE)) ||
		(wr_req && !write_done);

	// ************************************************************
	// read fill and write-through
	// ************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= mem_pkg::FILL_IDLE;
			valid <= '0;
			write_done <= 1'b0;
		end
		else
		begin
			write_done <= finish && is_write;
			case (state)
				mem_pkg::FILL_IDLE:
					if (start) state <= mem_pkg::FILL_REQUEST;
				mem_pkg::FILL_REQUEST:
					if (bus.ack) state <= mem_pkg::FILL_ACCESS;
				mem_pkg::FILL_ACCESS:
					state <= mem_pkg::FILL_WAIT_READY;
				mem_pkg::FILL_WAIT_READY:
				begin
					if (bus.ready)
					begin
						valid[fill_index] <= 1'b1; // allocate on hit or miss.
						state <= mem_pkg::FILL_IDLE;
					end
				end
				default:
					state <= mem_pkg::FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == mem_pkg::FILL_IDLE)
		begin
			fill_addr <= addr;
			fill_wdata <= wr_data;
			is_write <= wr_req;
		end
		if (finish)
		begin
			tags[fill_index] <= fill_addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
			data[fill_index] <= is_write ? fill_wdata : bus.rdata;
		end
	end

	assign bus.req = (state != mem_pkg::FILL_IDLE);
	assign bus.rd = (state == mem_pkg::FILL_ACCESS) && !is_write;
	assign bus.wr = (state == mem_pkg::FILL_ACCESS) && is_write;
	assign bus.addr = fill_addr;
	assign bus.wdata = fill_wdata;

endmodule

`default_nettype wire

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module icache (
	input wire clk,
	input wire reset,
	input wire mem_pkg::addr_t rd_addr,
	input wire rd_req,
	output logic rd_wait,
	output mem_pkg::word_t rd_data,
	bus_if.master bus
);

	logic [`MEM_LINES-1:0] valid;
	mem_pkg::tag_t tags [`MEM_LINES];
	mem_pkg::word_t data [`MEM_LINES];

	mem_pkg::fill_state_e state;
	mem_pkg::addr_t fill_addr;

	logic [`MEM_INDEX_BITS-1:0] index;
	logic [`MEM_INDEX_BITS-1:0] fill_index;
	mem_pkg::tag_t tag;
	logic hit;

	assign index = rd_addr[`MEM_INDEX_BITS+1:2];
	assign tag = rd_addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
	assign fill_index = fill_addr[`MEM_INDEX_BITS+1:2];
	assign hit = valid[index] && (tags[index] == tag);

	assign rd_data = data[index];
	assign rd_wait = rd_req && (!hit || state != mem_pkg::FILL_IDLE); // zero latency on a hit.

	// ************************************************************
	// miss fill
	// ************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= mem_pkg::FILL_IDLE;
			valid <= '0;
		end
		else
		begin
			case (state)
				mem_pkg::FILL_IDLE:
					if (rd_req && !hit) state <= mem_pkg::FILL_REQUEST;
				mem_pkg::FILL_REQUEST:
					if (bus.ack) state <= mem_pkg::FILL_ACCESS;
				mem_pkg::FILL_ACCESS:
					state <= mem_pkg::FILL_WAIT_READY; // rd strobe goes out here.
				mem_pkg::FILL_WAIT_READY:
				begin
					if (bus.ready)
					begin
						valid[fill_index] <= 1'b1;
						state <= mem_pkg::FILL_IDLE;
					end
				end
				default:
					state <= mem_pkg::FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == mem_pkg::FILL_IDLE)
			fill_addr <= rd_addr;
		if (state == mem_pkg::FILL_WAIT_READY && bus.ready)
		begin
			tags[fill_index] <= fill_addr[`MEM_WORD_BITS-1:`MEM_INDEX_BITS+2];
			data[fill_index] <= bus.rdata;
		end
	end

	assign bus.req = (state != mem_pkg::FILL_IDLE);
	assign bus.rd = (state == mem_pkg::FILL_ACCESS);
	assign bus.wr = 1'b0; // read only.
	assign bus.addr = fill_addr;
	assign bus.wdata = '0;

endmodule

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input wire clk,
	input wire reset,
	bus_if.arbiter icache_bus,
	bus_if.arbiter dcache_bus,
	bus_if.master ram_bus
);

	mem_pkg::grant_e grant;

	// ************************************************************
	// ownership, dcache first from idle, held until req drops
	// ************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
			grant <= mem_pkg::GRANT_NONE;
		else
		begin
			case (grant)
				mem_pkg::GRANT_NONE:
				begin
					if (dcache_bus.req)
						grant <= mem_pkg::GRANT_DCACHE;
					else if (icache_bus.req)
						grant <= mem_pkg::GRANT_ICACHE;
				end
				mem_pkg::GRANT_ICACHE:
					if (!icache_bus.req) grant <= mem_pkg::GRANT_NONE;
				mem_pkg::GRANT_DCACHE:
					if (!dcache_bus.req) grant <= mem_pkg::GRANT_NONE;
				default:
					grant <= mem_pkg::GRANT_NONE;
			endcase
		end
	end

	// ************************************************************
	// routing, only the owner reaches the ram
	// ************************************************************

	always_comb
	begin
		ram_bus.req = (grant != mem_pkg::GRANT_NONE);
		ram_bus.addr = '0;
		ram_bus.wdata = '0;
		ram_bus.rd = 1'b0;
		ram_bus.wr = 1'b0;
		icache_bus.ack = 1'b0;
		icache_bus.rdata = '0;
		icache_bus.ready = 1'b0;
		dcache_bus.ack = 1'b0;
		dcache_bus.rdata = '0;
		dcache_bus.ready = 1'b0;
		case (grant)
			mem_pkg::GRANT_ICACHE:
			begin
				ram_bus.addr = icache_bus.addr;
				ram_bus.wdata = icache_bus.wdata;
				ram_bus.rd = icache_bus.rd;
				ram_bus.wr = icache_bus.wr;
				icache_bus.ack = icache_bus.req;
				icache_bus.rdata = ram_bus.rdata;
				icache_bus.ready = ram_bus.ready;
			end
			mem_pkg::GRANT_DCACHE:
			begin
				ram_bus.addr = dcache_bus.addr;
				ram_bus.wdata = dcache_bus.wdata;
				ram_bus.rd = dcache_bus.rd;
				ram_bus.wr = dcache_bus.wr;
				dcache_bus.ack = dcache_bus.req;
				dcache_bus.rdata = ram_bus.rdata;
				dcache_bus.ready = ram_bus.ready;
			end
			default:
				ram_bus.req = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bus_if;

	logic req;
	logic ack;
	mem_pkg::addr_t addr;
	mem_pkg::word_t rdata;
	mem_pkg::word_t wdata;
	logic rd;
	logic wr;
	logic ready;

	modport master (
		output req, addr, wdata, rd, wr,
		input ack, rdata, ready
	);

	modport arbiter (
		input req, addr, wdata, rd, wr,
		output ack, rdata, ready
	);

	// the ram sees only the routed strobes, not req and ack.
	modport slave (
		input addr, wdata, rd, wr,
		output rdata, ready
	);

endinterface

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

	typedef logic [`MEM_WORD_BITS-1:0] word_t;
	typedef logic [`MEM_WORD_BITS-1:0] addr_t; // byte address, bits 1:0 ignored.

	// everything above the index and the byte offset.
	typedef logic [`MEM_WORD_BITS-`MEM_INDEX_BITS-3:0] tag_t;

	// miss handling sequence shared by both caches.
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_REQUEST,
		FILL_ACCESS,
		FILL_WAIT_READY
	} fill_state_e;

	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_ICACHE,
		GRANT_DCACHE
	} grant_e;

endpackage

`default_nettype wire

// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// ************************************************************
// widths and geometry of the memory side
// ************************************************************

`define MEM_WORD_BITS 32 // data and byte address width.
`define MEM_LINES 16 // direct-mapped, one word per line.
`define MEM_INDEX_BITS 4 // index is address bits 5:2.
`define MEM_RAM_WORDS 64 // ram index is address bits 7:2.

`endif
